/* verilog.f */
vp_sys_pkg.sv
vp_io_pkg.sv
vp_config.sv
vp_clk_enables.sv
vp_cart_mapper.sv
vp_color.sv
vp_input_decoder.sv
vp_glue_top.sv
vp_glue_assertions.sv
tb_vp_glue.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator, exits non-zero on any failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
	--top-module tb_vp_glue -o tb_vp_glue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_vp_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
exit 0

/* tb_vp_glue.sv */
// Random stimulus from seed 54; checks rely on one cycle of colour latency and two of key latency
module tb_vp_glue;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_INTERVALS = 6;
	localparam int N_DOWNLOADS = 8;
	localparam int N_ACCESSES = 64;
	localparam int N_PIXELS = 200;
	localparam int N_KEYS = 100;
	localparam int N_JOY = 50;
	// Worst case cycles of all test groups, doubled, in ns
	localparam int WATCHDOG_NS = 2 * 20 * (3 * (N_INTERVALS + 4) * 12
		+ N_DOWNLOADS * (16384 + 3 + N_ACCESSES) + 2 * N_PIXELS + 9 * N_KEYS
		+ 2 * (N_JOY + 1) + 10);

	// PS/2 set 2 codes in key_text order, then GUI left, GUI right, enter, backspace
	localparam logic [7:0] KEY_CODES [46] = '{
		8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46, 8'h45,
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
		8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
		8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a, 8'h29, 8'h79, 8'h7b, 8'h7c,
		8'h4a, 8'h55, 8'h1f, 8'h27, 8'h5a, 8'h66
	};
	localparam logic [7:0] SPECIAL_CODES [4] = '{8'h11, 8'h12, 8'd10, 8'd8};
	string key_text = "1234567890abcdefghijklmnopqrstuvwxyz +-*/=";
	// Pad key bit 0 is key 1, bit 9 is key 0
	string digit_text = "1234567890";

	logic clk_sys = 1'b0;
	logic reset;
	vp_sys_pkg::cfg_t cfg;
	vp_sys_pkg::load_t load;
	vp_sys_pkg::cart_bus_t cart;
	vp_io_pkg::pixel_t pixel;
	vp_io_pkg::ps2_key_t ps2;
	vp_io_pkg::joy_pad_t pad_a;
	vp_io_pkg::joy_pad_t pad_b;
	logic cpu_en;
	logic vdc_en;
	logic [13:0] rom_addr;
	logic rom_wr;
	logic rom_rd;
	vp_io_pkg::rgb_t rgb;
	logic key_valid;
	vp_io_pkg::key_ev_t key;
	vp_io_pkg::joy_dir_t joy;

	int cyc = 0;
	int checks = 0;
	int errors = 0;
	logic [31:0] rng_state = 32'd54;
	// Cartridge state after the last download
	int model_size = 0;
	logic model_xrom = 1'b0;

	vp_glue_top u_vp_glue_top (
		.clk_sys (clk_sys),
		.reset (reset),
		.cfg_i (cfg),
		.load_i (load),
		.cart_i (cart),
		.pixel_i (pixel),
		.ps2_i (ps2),
		.pad_a_i (pad_a),
		.pad_b_i (pad_b),
		.cpu_en_o (cpu_en),
		.vdc_en_o (vdc_en),
		.rom_addr_o (rom_addr),
		.rom_wr_o (rom_wr),
		.rom_rd_o (rom_rd),
		.rgb_o (rgb),
		.key_valid_o (key_valid),
		.key_o (key),
		.joy_o (joy)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) cyc <= cyc + 1;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic compare_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("Checks: %0d, errors: %0d", checks, errors);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [13:0] expected_rom_addr(input vp_sys_pkg::cart_bus_t c,
		input int size, input logic xrom);
		if (xrom)
			return {2'b00, c.addr};
		if (size == 4096)
			return 14'({c.bank0, c.addr[11], c.addr[9:0]});
		if (size == 8192)
			return 14'({c.bank1, c.bank0, c.addr[11], c.addr[9:0]});
		if (size == 16384)
			return {c.bank1, c.bank0, c.addr};
		return 14'({c.addr[11], c.addr[9:0]});
	endfunction

	function automatic logic expected_rom_rd(input vp_sys_pkg::cart_bus_t c, input logic xrom);
		return xrom ? (!(c.cs_n && c.bank0) && c.rd_n) : !c.rd_n;
	endfunction

	function automatic vp_io_pkg::rgb_t expected_rgb(input logic [2:0] mode,
		input vp_io_pkg::pixel_t px);
		logic [7:0] p;
		logic [7:0] s;
		int n;
		vp_io_pkg::rgb_t res;
		res = vp_io_pkg::PALETTE[{px.r, px.g, px.b, px.luma}];
		if (mode == 3'd0 || mode == 3'd4)
			return res;
		// Red leads in modes 1 to 3, blue in 5 to 7
		p = (mode < 3'd4) ? res.r : res.b;
		s = (mode < 3'd4) ? res.b : res.r;
		n = (mode == 3'd1 || mode == 3'd7) ? 7 : ((mode == 3'd2 || mode == 3'd6) ? 6 : 4);
		res.r = ((p >> (8 - n)) << (8 - n)) | (s >> n);
		res.g = ((res.g >> n) << n) | (p >> (8 - n));
		res.b = res.r;
		return res;
	endfunction

	function automatic logic [7:0] expected_ascii(input logic [7:0] code);
		for (int i = 0; i < 46; i++) begin
			if (KEY_CODES[i] == code) begin
				if (i < 42)
					return key_text[i];
				return SPECIAL_CODES[i - 42];
			end
		end
		return 8'h00;
	endfunction

	function automatic logic [7:0] lowest_key_ascii(input logic [9:0] keys);
		for (int i = 0; i < 10; i++) begin
			if (keys[i])
				return digit_text[i];
		end
		return 8'h00;
	endfunction

	function automatic vp_io_pkg::joy_dir_t expected_joy(input logic swap,
		input vp_io_pkg::joy_pad_t a, input vp_io_pkg::joy_pad_t b);
		vp_io_pkg::joy_pad_t f;
		vp_io_pkg::joy_pad_t s;
		vp_io_pkg::joy_dir_t j;
		f = swap ? b : a;
		s = swap ? a : b;
		j.up = ~{f.up, s.up};
		j.down = ~{f.down, s.down};
		j.left = ~{f.left, s.left};
		j.right = ~{f.right, s.right};
		j.action = ~{f.action, s.action};
		j.reset = !(a.reset && b.reset);
		return j;
	endfunction

	//////////////////////////////
	// Test items
	//////////////////////////////

	// First two pulses may belong to the old standard
	task automatic check_enables(input int cpu_div, input int vdc_div);
		int div [2];
		int seen [2] = '{0, 0};
		int done [2] = '{0, 0};
		int last [2] = '{0, 0};
		logic en [2];
		string names [2] = '{"cpu_en period", "vdc_en period"};
		div[0] = cpu_div;
		div[1] = vdc_div;
		while (done[0] < N_INTERVALS || done[1] < N_INTERVALS) begin
			@(negedge clk_sys);
			en[0] = cpu_en;
			en[1] = vdc_en;
			for (int i = 0; i < 2; i++) begin
				if (en[i]) begin
					seen[i]++;
					if (seen[i] > 2 && done[i] < N_INTERVALS) begin
						compare_value(cyc - last[i], div[i], names[i]);
						done[i]++;
					end
					last[i] = cyc;
				end
			end
		end
	endtask

	task automatic run_download(input logic [2:0] index, input int length);
		load.download = 1'b1;
		load.wr = 1'b0;
		load.index = index;
		load.addr = '0;
		#5;
		compare_value(32'(rom_wr), 32'd0, "rom_wr without wr");
		@(negedge clk_sys);
		// One byte per cycle
		for (int n = 0; n < length; n++) begin
			load.wr = 1'b1;
			load.addr = 14'(next_random());
			#5;
			compare_value(32'(rom_wr), 32'd1, "rom_wr");
			compare_value(32'(rom_addr), 32'(load.addr), "rom_addr during download");
			@(negedge clk_sys);
		end
		load = '0;
		model_size = length;
		model_xrom = (index == 3'd2);
		@(negedge clk_sys);
	endtask

	task automatic check_cart_access();
		logic [31:0] r;
		r = next_random();
		cart = r[15:0];
		#5;
		compare_value(32'(rom_addr), 32'(expected_rom_addr(cart, model_size, model_xrom)),
			"rom_addr");
		compare_value(32'(rom_rd), 32'(expected_rom_rd(cart, model_xrom)), "rom_rd");
		compare_value(32'(rom_wr), 32'd0, "rom_wr outside download");
		@(negedge clk_sys);
	endtask

	// Contrast goes through the settings register first
	task automatic check_pixel();
		logic [31:0] r;
		r = next_random();
		cfg.contrast = r[2:0];
		@(negedge clk_sys);
		pixel = r[7:4];
		@(negedge clk_sys);
		compare_value(32'(rgb), 32'(expected_rgb(cfg.contrast, pixel)), "rgb");
	endtask

	task automatic expect_key_event(input logic check_ascii, input logic [7:0] ascii,
		input logic released);
		@(negedge clk_sys);
		compare_value(32'(key_valid), 32'd0, "key_valid one cycle after event");
		@(negedge clk_sys);
		compare_value(32'(key_valid), 32'd1, "key_valid two cycles after event");
		if (check_ascii)
			compare_value(32'(key.ascii), 32'(ascii), "key ascii");
		compare_value(32'(key.released), 32'(released), "key released");
		@(negedge clk_sys);
		compare_value(32'(key_valid), 32'd0, "key_valid after pulse");
	endtask

	task automatic check_ps2_key();
		logic [31:0] r;
		logic [7:0] code;
		int idx;
		r = next_random();
		idx = int'(r[15:8]) % 46;
		// Half table codes, half any code
		code = r[0] ? KEY_CODES[idx] : r[23:16];
		ps2.toggle = ~ps2.toggle;
		ps2.pressed = r[1];
		ps2.extended = r[2];
		ps2.code = code;
		expect_key_event(1'b1, expected_ascii(code),
			!ps2.pressed && ((pad_a.num | pad_b.num) == 10'd0));
	endtask

	task automatic check_pad_key();
		logic [31:0] r;
		logic [9:0] keys;
		r = next_random();
		keys = r[9:0];
		if (keys == 10'd0)
			keys = 10'h200;
		case (r[31:30])
			2'd0: pad_a.num = keys;
			2'd1: pad_b.num = keys;
			default: begin
				pad_a.num = keys & r[19:10];
				pad_b.num = keys & ~r[19:10];
			end
		endcase
		expect_key_event(1'b1, lowest_key_ascii(keys),
			!ps2.pressed && ((pad_a.num | pad_b.num) == 10'd0));
		// Key release, code not defined
		pad_a.num = '0;
		pad_b.num = '0;
		expect_key_event(1'b0, 8'h00, !ps2.pressed && ((pad_a.num | pad_b.num) == 10'd0));
	endtask

	task automatic check_joystick();
		logic [31:0] r;
		r = next_random();
		pad_a = {10'd0, r[5:0]};
		pad_b = {10'd0, r[11:6]};
		#5;
		compare_value(32'(joy), 32'(expected_joy(cfg.joy_swap, pad_a, pad_b)), "joy");
		@(negedge clk_sys);
	endtask

	//////////////////////////////
	// Sequence
	//////////////////////////////

	initial begin
		int length;
		logic [31:0] r;
		reset = 1'b1;
		cfg = '0;
		load = '0;
		cart = '0;
		pixel = '0;
		ps2 = '0;
		pad_a = '0;
		pad_b = '0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		// NTSC, PAL, then NTSC again
		check_enables(8, 6);
		cfg.pal = 1'b1;
		check_enables(12, 10);
		cfg.pal = 1'b0;
		check_enables(8, 6);

		// Size kinds in turn, index 0 images first and XROM index 2 after
		for (int d = 0; d < N_DOWNLOADS; d++) begin
			r = next_random();
			case (d % 4)
				0: length = 4096;
				1: length = 8192;
				2: length = 16384;
				default: length = 1 + int'(r[10:0]);
			endcase
			run_download(d[2] ? 3'd2 : 3'd0, length);
			repeat (N_ACCESSES) check_cart_access();
		end

		repeat (N_PIXELS) check_pixel();

		repeat (N_KEYS) check_ps2_key();
		repeat (N_KEYS) check_pad_key();

		// Plain routing, then swapped
		for (int sw = 0; sw < 2; sw++) begin
			cfg.joy_swap = sw[0];
			@(negedge clk_sys);
			repeat (N_JOY) check_joystick();
		end
		pad_a = '0;
		pad_b = '0;

		print_counts();
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		print_counts();
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* vp_glue_assertions.sv */
// Bound into vp_glue_top; checks are off while reset is high
module vp_glue_assertions (
	input logic clk_sys,
	input logic reset,
	input logic cpu_en_i,
	input logic key_valid_i,
	input logic rom_wr_i,
	input vp_sys_pkg::load_t load_i
);
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////
	// Strobes
	//////////////////////////////

	// CPU enable lasts one cycle
	cpu_en_single: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_i |=> !cpu_en_i)
		else $error("cpu_en high for more than one cycle");

	// Key event lasts one cycle
	key_valid_single: assert property (@(posedge clk_sys) disable iff (reset)
		key_valid_i |=> !key_valid_i)
		else $error("key_valid high for more than one cycle");

	// Host writes only while downloading
	rom_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		rom_wr_i |-> load_i.download)
		else $error("rom_wr high without a download");

endmodule

bind vp_glue_top vp_glue_assertions u_vp_glue_assertions (
	.clk_sys (clk_sys),
	.reset (reset),
	.cpu_en_i (cpu_en_o),
	.key_valid_i (key_valid_o),
	.rom_wr_i (rom_wr_o),
	.load_i (load_i)
);

/* vp_glue_top.sv */
// Glue between host frame and console; settings reach the blocks one cycle after cfg_i
module vp_glue_top (
	input logic clk_sys,
	input logic reset,
	input vp_sys_pkg::cfg_t cfg_i,
	input vp_sys_pkg::load_t load_i,
	input vp_sys_pkg::cart_bus_t cart_i,
	input vp_io_pkg::pixel_t pixel_i,
	input vp_io_pkg::ps2_key_t ps2_i,
	input vp_io_pkg::joy_pad_t pad_a_i,
	input vp_io_pkg::joy_pad_t pad_b_i,
	output logic cpu_en_o,
	output logic vdc_en_o,
	output logic [vp_sys_pkg::ROM_AW-1:0] rom_addr_o,
	output logic rom_wr_o,
	output logic rom_rd_o,
	output vp_io_pkg::rgb_t rgb_o,
	output logic key_valid_o,
	output vp_io_pkg::key_ev_t key_o,
	output vp_io_pkg::joy_dir_t joy_o
);

	vp_sys_pkg::cfg_t cfg;
	logic std_change;

	// Settings register
	vp_config u_vp_config (
		.clk_sys (clk_sys),
		.reset (reset),
		.cfg_i (cfg_i),
		.cfg_o (cfg),
		.std_change_o (std_change)
	);

	// CPU and VDC enables
	vp_clk_enables u_vp_clk_enables (
		.clk_sys (clk_sys),
		.reset (reset),
		.cfg_pal_i (cfg.pal),
		.std_change_i (std_change),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	// Cartridge ROM port
	vp_cart_mapper u_vp_cart_mapper (
		.clk_sys (clk_sys),
		.reset (reset),
		.load_i (load_i),
		.cart_i (cart_i),
		.rom_addr_o (rom_addr_o),
		.rom_wr_o (rom_wr_o),
		.rom_rd_o (rom_rd_o)
	);

	// Pixel colour
	vp_color u_vp_color (
		.clk_sys (clk_sys),
		.reset (reset),
		.contrast_i (cfg.contrast),
		.pixel_i (pixel_i),
		.rgb_o (rgb_o)
	);

	// Keyboard and joysticks
	vp_input_decoder u_vp_input_decoder (
		.clk_sys (clk_sys),
		.reset (reset),
		.joy_swap_i (cfg.joy_swap),
		.ps2_i (ps2_i),
		.pad_a_i (pad_a_i),
		.pad_b_i (pad_b_i),
		.key_valid_o (key_valid_o),
		.key_o (key_o),
		.joy_o (joy_o)
	);

endmodule

/* vp_input_decoder.sv */
// Key events are strobes with no hold; two events in adjacent cycles give adjacent key_valid pulses
module vp_input_decoder (
	input logic clk_sys,
	input logic reset,
	input logic joy_swap_i,
	input vp_io_pkg::ps2_key_t ps2_i,
	input vp_io_pkg::joy_pad_t pad_a_i,
	input vp_io_pkg::joy_pad_t pad_b_i,
	output logic key_valid_o,
	output vp_io_pkg::key_ev_t key_o,
	output vp_io_pkg::joy_dir_t joy_o
);

	// PS/2 set 2 code to keyboard matrix code, extended bit not looked at
	function automatic logic [7:0] ps2_to_ascii(input logic [7:0] code);
		case (code)
			8'h16: return "1";
			8'h1e: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2e: return "5";
			8'h36: return "6";
			8'h3d: return "7";
			8'h3e: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1c: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2b: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3b: return "j";
			8'h42: return "k";
			8'h4b: return "l";
			8'h3a: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4d: return "p";
			8'h15: return "q";
			8'h2d: return "r";
			8'h1b: return "s";
			8'h2c: return "t";
			8'h3c: return "u";
			8'h2a: return "v";
			8'h1d: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1a: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7b: return "-";
			8'h7c: return "*";
			8'h4a: return "/";
			8'h55: return "=";
			// GUI keys answer the yes/no prompts
			8'h1f: return vp_io_pkg::KEY_YES;
			8'h27: return vp_io_pkg::KEY_NO;
			8'h5a: return vp_io_pkg::KEY_ENTER;
			8'h66: return vp_io_pkg::KEY_BKSP;
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed pad key wins, bit 9 is key 0
	function automatic logic [7:0] num_to_ascii(input logic [9:0] num);
		logic [7:0] ascii;
		ascii = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (num[i])
				ascii = (i == 9) ? "0" : 8'("1" + i);
		end
		return ascii;
	endfunction

	logic [9:0] num;
	logic ps2_hit;
	logic tog_prev_q;
	logic [9:0] num_prev_q;
	logic ps2_chg_q;
	logic joy_chg_q;
	logic ps2_rel_q;
	logic joy_rel_q;
	logic [7:0] ps2_ascii_q;
	logic [7:0] joy_ascii_q;
	logic key_valid_q;
	vp_io_pkg::key_ev_t key_q;
	vp_io_pkg::joy_pad_t first;
	vp_io_pkg::joy_pad_t second;

	assign num = pad_a_i.num | pad_b_i.num;
	assign ps2_hit = (ps2_i.toggle != tog_prev_q);

	//////////////////////////////
	// Event detection
	//////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			tog_prev_q <= 1'b0;
			num_prev_q <= '0;
			ps2_chg_q <= 1'b0;
			joy_chg_q <= 1'b0;
			key_valid_q <= 1'b0;
		end else begin
			tog_prev_q <= ps2_i.toggle;
			num_prev_q <= num;
			ps2_chg_q <= ps2_hit;
			joy_chg_q <= |(num ^ num_prev_q);
			key_valid_q <= ps2_chg_q | joy_chg_q;
		end
	end

	// Key codes and flags, second stage picks PS/2 first
	always_ff @(posedge clk_sys) begin
		ps2_rel_q <= ~ps2_i.pressed;
		joy_rel_q <= (num == 10'd0);
		if (ps2_hit)
			ps2_ascii_q <= ps2_to_ascii(ps2_i.code);
		else if (num != 10'd0)
			joy_ascii_q <= num_to_ascii(num);
		key_q.ascii <= ps2_chg_q ? ps2_ascii_q : joy_ascii_q;
		key_q.released <= ps2_rel_q & joy_rel_q;
	end

	assign key_valid_o = key_valid_q;
	assign key_o = key_q;

	//////////////////////////////
	// Joystick routing
	//////////////////////////////

	assign first = joy_swap_i ? pad_b_i : pad_a_i;
	assign second = joy_swap_i ? pad_a_i : pad_b_i;

	assign joy_o.up = {~first.up, ~second.up};
	assign joy_o.down = {~first.down, ~second.down};
	assign joy_o.left = {~first.left, ~second.left};
	assign joy_o.right = {~first.right, ~second.right};
	assign joy_o.action = {~first.action, ~second.action};
	// Console reset only when both pads hold their reset button
	assign joy_o.reset = ~(first.reset & second.reset);

endmodule

/* vp_color.sv */
// Registered palette lookup; contrast modes other than 0 and 4 give equal red and blue outputs
module vp_color (
	input logic clk_sys,
	input logic reset,
	input logic [2:0] contrast_i,
	input vp_io_pkg::pixel_t pixel_i,
	output vp_io_pkg::rgb_t rgb_o
);

	logic [23:0] lut;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	// Primary and secondary channel of the contrast mode
	logic [7:0] p;
	logic [7:0] s;
	vp_io_pkg::rgb_t rgb_d;
	vp_io_pkg::rgb_t rgb_q;

	// Struct order makes r the top index bit
	assign lut = vp_io_pkg::PALETTE[pixel_i];
	assign r = lut[23:16];
	assign g = lut[15:8];
	assign b = lut[7:0];

	// Modes 5 to 7 favour blue
	assign p = contrast_i[2] ? b : r;
	assign s = contrast_i[2] ? r : b;

	//////////////////////////////
	// Contrast rearrangement
	//////////////////////////////

	always_comb begin
		rgb_d.r = r;
		rgb_d.g = g;
		rgb_d.b = b;
		case (contrast_i)
			3'd1, 3'd7: begin
				rgb_d.r = {p[7:1], s[7]};
				rgb_d.g = {g[7], p[7:1]};
				rgb_d.b = {p[7:1], s[7]};
			end
			3'd2, 3'd6: begin
				rgb_d.r = {p[7:2], s[7:6]};
				rgb_d.g = {g[7:6], p[7:2]};
				rgb_d.b = {p[7:2], s[7:6]};
			end
			3'd3, 3'd5: begin
				rgb_d.r = {p[7:4], s[7:4]};
				rgb_d.g = {g[7:4], p[7:4]};
				rgb_d.b = {p[7:4], s[7:4]};
			end
			// 0 and 4 pass the palette through
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			rgb_q <= '0;
		else
			rgb_q <= rgb_d;
	end

	assign rgb_o = rgb_q;

endmodule

/* vp_cart_mapper.sv */
// Bank layout is chosen only by exact download size; a wr in the download's first cycle is not counted
module vp_cart_mapper (
	input logic clk_sys,
	input logic reset,
	input vp_sys_pkg::load_t load_i,
	input vp_sys_pkg::cart_bus_t cart_i,
	output logic [vp_sys_pkg::ROM_AW-1:0] rom_addr_o,
	output logic rom_wr_o,
	output logic rom_rd_o
);

	logic dl_prev_q;
	logic [15:0] size_q;
	logic xrom_q;
	// Host owns the ROM while loading a cartridge or XROM image
	logic dl_sel;
	logic [vp_sys_pkg::ROM_AW-1:0] map_addr;

	//////////////////////////////
	// Download tracking
	//////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_prev_q <= 1'b0;
			size_q <= '0;
			xrom_q <= 1'b0;
		end else begin
			dl_prev_q <= load_i.download;
			if (load_i.download && !dl_prev_q) begin
				size_q <= '0;
				xrom_q <= (load_i.index == vp_sys_pkg::XROM_INDEX);
			end else if (load_i.download && load_i.wr) begin
				size_q <= size_q + 16'd1;
			end
		end
	end

	//////////////////////////////
	// Address mapping
	//////////////////////////////

	always_comb begin
		if (xrom_q) begin
			map_addr = {2'b00, cart_i.addr};
		end else begin
			case (size_q)
				vp_sys_pkg::SIZE_4K:
					map_addr = {2'b00, cart_i.bank0, cart_i.addr[11], cart_i.addr[9:0]};
				vp_sys_pkg::SIZE_8K:
					map_addr = {1'b0, cart_i.bank1, cart_i.bank0, cart_i.addr[11], cart_i.addr[9:0]};
				// 12K usable, banked as 16K
				vp_sys_pkg::SIZE_16K:
					map_addr = {cart_i.bank1, cart_i.bank0, cart_i.addr};
				default:
					map_addr = {3'b000, cart_i.addr[11], cart_i.addr[9:0]};
			endcase
		end
	end

	assign dl_sel = load_i.download && (load_i.index < 3'd3);
	assign rom_addr_o = dl_sel ? load_i.addr : map_addr;
	assign rom_wr_o = dl_sel && load_i.wr;
	// XROM reads also through the bank0 data window, see cs_n term
	assign rom_rd_o = xrom_q ? (~(cart_i.cs_n & cart_i.bank0) & cart_i.rd_n) : ~cart_i.rd_n;

endmodule

/* vp_clk_enables.sv */
// CPU and VDC enables from clk_sys; counters restart on a standard change, no phase relation kept
module vp_clk_enables (
	input logic clk_sys,
	input logic reset,
	input logic cfg_pal_i,
	input logic std_change_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Slot 0 is the CPU divider, slot 1 the VDC divider
	// 4 bits cover the longest period of 12
	logic [1:0][3:0] ctr_q;
	logic [1:0][3:0] last;
	logic [1:0] en_q;

	// Last count of each period for the current standard
	always_comb begin
		last[0] = cfg_pal_i ? 4'(vp_sys_pkg::CPU_DIV_PAL - 1) : 4'(vp_sys_pkg::CPU_DIV_NTSC - 1);
		last[1] = cfg_pal_i ? 4'(vp_sys_pkg::VDC_DIV_PAL - 1) : 4'(vp_sys_pkg::VDC_DIV_NTSC - 1);
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ctr_q <= '0;
			en_q <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (std_change_i) begin
					ctr_q[i] <= '0;
					en_q[i] <= 1'b0;
				end else if (ctr_q[i] >= last[i]) begin
					// Wrap, also catches a count left over from the longer PAL period
					ctr_q[i] <= '0;
					en_q[i] <= 1'b1;
				end else begin
					ctr_q[i] <= ctr_q[i] + 4'd1;
					en_q[i] <= 1'b0;
				end
			end
		end
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

endmodule

/* vp_config.sv */
// Settings sampled every cycle with one cycle of latency; std_change comes one cycle after that
module vp_config (
	input logic clk_sys,
	input logic reset,
	input vp_sys_pkg::cfg_t cfg_i,
	output vp_sys_pkg::cfg_t cfg_o,
	output logic std_change_o
);

	// Sampled settings
	vp_sys_pkg::cfg_t cfg_q;
	// Standard bit one cycle behind cfg_q
	logic pal_prev_q;
	logic std_change_q;

	//////////////////////////////
	// Sampling
	//////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg_q <= '0;
			pal_prev_q <= 1'b0;
			std_change_q <= 1'b0;
		end else begin
			cfg_q <= cfg_i;
			pal_prev_q <= cfg_q.pal;
			// NTSC/PAL switch restarts the video timing
			std_change_q <= (cfg_q.pal != pal_prev_q);
		end
	end

	assign cfg_o = cfg_q;
	assign std_change_o = std_change_q;

endmodule

/* vp_io_pkg.sv */
// Palette, pixel, joystick and key definitions; pad bit layout follows the host joystick word
package vp_io_pkg;

	//////////////////////////////
	// Video
	//////////////////////////////

	// Calibrated palette, indexed by {r, g, b, luma}
	localparam logic [23:0] PALETTE [0:15] = '{
		24'h000000, 24'h676767,
		24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151,
		24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a,
		24'hcecece, 24'hffffff
	};

	// Console pixel, r is the top index bit
	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic luma;
	} pixel_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	//////////////////////////////
	// Joysticks and keys
	//////////////////////////////

	// One host pad, all bits active high
	// num[0] is key 1, num[9] is key 0
	typedef struct packed {
		logic [9:0] num;
		logic reset;
		logic action;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_pad_t;

	// Console joystick lines, active low
	// Bit 1 is the first pad, bit 0 the second
	typedef struct packed {
		logic [1:0] up;
		logic [1:0] down;
		logic [1:0] left;
		logic [1:0] right;
		logic [1:0] action;
		logic reset;
	} joy_dir_t;

	// Host PS/2 key word
	typedef struct packed {
		logic toggle;
		logic pressed;
		logic extended;
		logic [7:0] code;
	} ps2_key_t;

	// Key event towards the keyboard matrix
	typedef struct packed {
		logic [7:0] ascii;
		logic released;
	} key_ev_t;

	// Special key codes
	localparam logic [7:0] KEY_YES = 8'h11;
	localparam logic [7:0] KEY_NO = 8'h12;
	localparam logic [7:0] KEY_ENTER = 8'd10;
	localparam logic [7:0] KEY_BKSP = 8'd8;

endpackage

/* vp_sys_pkg.sv */
// Clocking, cartridge and settings definitions; dividers assume an NTSC or PAL clk_sys plan
package vp_sys_pkg;

	//////////////////////////////
	// Clock enable periods
	//////////////////////////////

	// CPU enable period in clk_sys cycles
	localparam int unsigned CPU_DIV_NTSC = 8;
	localparam int unsigned CPU_DIV_PAL = 12;
	// VDC enable period in clk_sys cycles
	localparam int unsigned VDC_DIV_NTSC = 6;
	localparam int unsigned VDC_DIV_PAL = 10;

	//////////////////////////////
	// Cartridge and ROM
	//////////////////////////////

	// Console cartridge address width
	localparam int unsigned CART_AW = 12;
	// Cartridge ROM address width, 16K max
	localparam int unsigned ROM_AW = 14;

	// Download byte counts that select a bank layout
	localparam logic [15:0] SIZE_4K = 16'd4096;
	localparam logic [15:0] SIZE_8K = 16'd8192;
	localparam logic [15:0] SIZE_16K = 16'd16384;

	// Download index of an XROM image
	localparam logic [2:0] XROM_INDEX = 3'd2;

	// Menu settings as sampled
	typedef struct packed {
		logic pal;
		logic joy_swap;
		logic [2:0] contrast;
	} cfg_t;

	// Cartridge port as seen from the console
	typedef struct packed {
		logic [CART_AW-1:0] addr;
		logic bank0;
		logic bank1;
		logic cs_n;
		logic rd_n;
	} cart_bus_t;

	// Host download port
	typedef struct packed {
		logic download;
		logic wr;
		logic [2:0] index;
		logic [ROM_AW-1:0] addr;
	} load_t;

endpackage
